// File: src/spi_pkg.sv
package spi_pkg;

  // one spi transfer unit, msb first on the wire
  parameter int BYTE_W = 8;

  // bits needed to count through one byte
  parameter int BIT_CNT_W = $clog2(BYTE_W);

  // register address field of the command byte
  parameter int ADDR_W = 4;
  parameter int CMD_ADDR_LSB = 0;

  // set means write, clear means read
  parameter int CMD_WRITE_BIT = 7;

  // default bank size, counter sits in the last slot
  parameter int NUM_REGS_DEFAULT = 16;

  typedef logic [BYTE_W-1:0]    spi_byte_t;
  typedef logic [ADDR_W-1:0]    reg_addr_t;
  typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

  // frame controller states
  typedef enum logic [2:0] {
    IDLE,
    // waiting for the command byte
    CMD,
    DATA_WR,
    DATA_RD,
    // data byte seen, waiting for ssel to rise
    DONE
  } frame_state_t;

endpackage

// File: src/spi_pin_if.sv
`timescale 1ns/1ps

interface spi_pin_if;

  // sck edges, one clk cycle each
  logic sck_rise;
  logic sck_fall;

  // ssel level and its edges
  logic ssel_active;
  logic frame_start;
  logic frame_end;

  // mosi, aligned with the sck edge outputs
  logic mosi_bit;

  // driven by the synchronizer only
  modport src (
    output sck_rise, sck_fall,
    output ssel_active, frame_start, frame_end,
    output mosi_bit
  );

  // every consumer inside the slave
  modport dst (
    input sck_rise, sck_fall,
    input ssel_active, frame_start, frame_end,
    input mosi_bit
  );

endinterface

// File: src/spi_pin_sync.sv
`timescale 1ns/1ps

module spi_pin_sync #(
  parameter int SYNC_STAGES = 3
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   sck,
  input  logic   ssel,
  input  logic   mosi,
  spi_pin_if.src pins
);

  // newest sample enters at bit 0
  logic [SYNC_STAGES-1:0] sck_q;
  logic [SYNC_STAGES-1:0] ssel_q;
  logic [SYNC_STAGES-1:0] mosi_q;

  // ssel chain resets to all ones, so no frame_start comes out of reset
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sck_q  <= '0;
      ssel_q <= '1;
      mosi_q <= '0;
    end
    else
    begin
      sck_q  <= {sck_q[SYNC_STAGES-2:0], sck};
      ssel_q <= {ssel_q[SYNC_STAGES-2:0], ssel};
      mosi_q <= {mosi_q[SYNC_STAGES-2:0], mosi};
    end
  end

  // edges from the two oldest stages, old value on the left
  assign pins.sck_rise = (sck_q[SYNC_STAGES-1 -: 2] == 2'b01);
  assign pins.sck_fall = (sck_q[SYNC_STAGES-1 -: 2] == 2'b10);

  // ssel is active low
  assign pins.ssel_active = ~ssel_q[SYNC_STAGES-2];
  // frame opens on the falling edge, closes on the rising edge
  assign pins.frame_start = (ssel_q[SYNC_STAGES-1 -: 2] == 2'b10);
  assign pins.frame_end   = (ssel_q[SYNC_STAGES-1 -: 2] == 2'b01);

  // same stage as the newer half of the edge detectors
  assign pins.mosi_bit = mosi_q[SYNC_STAGES-2];

endmodule

// File: src/spi_rx_shift.sv
`timescale 1ns/1ps

module spi_rx_shift (
  input  logic              clk,
  input  logic              rst_n,
  spi_pin_if.dst            pins,
  output logic              byte_valid,
  output spi_pkg::spi_byte_t byte_data
);

  localparam spi_pkg::bit_cnt_t LAST_BIT = spi_pkg::bit_cnt_t'(spi_pkg::BYTE_W - 1);

  spi_pkg::bit_cnt_t bit_cnt;
  spi_pkg::spi_byte_t shift_q;

  // bit counter and byte strobe
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt    <= '0;
      byte_valid <= 1'b0;
    end
    else
    begin
      // strobe lands one clk after the eighth rising edge
      byte_valid <= pins.ssel_active && pins.sck_rise && (bit_cnt == LAST_BIT);
      // leaving ssel drops any partial byte
      if (!pins.ssel_active)
        bit_cnt <= '0;
      else if (pins.sck_rise)
        // wraps to zero so the next byte follows directly
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // msb arrives first, so shift towards the msb
  always_ff @(posedge clk)
  begin
    if (pins.ssel_active && pins.sck_rise)
      shift_q <= {shift_q[spi_pkg::BYTE_W-2:0], pins.mosi_bit};
  end

  // holds the full byte while byte_valid is high
  assign byte_data = shift_q;

endmodule

// File: src/spi_tx_shift.sv
`timescale 1ns/1ps

module spi_tx_shift (
  input  logic               clk,
  input  logic               rst_n,
  spi_pin_if.dst             pins,
  input  logic               tx_load,
  input  spi_pkg::spi_byte_t rd_data,
  output logic               miso
);

  spi_pkg::spi_byte_t shift_q;

  // zero except during the data byte of a read frame
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shift_q <= '0;
    end
    else if (pins.frame_end)
    begin
      // nothing left over for the next frame
      shift_q <= '0;
    end
    else if (tx_load)
    begin
      // load comes with the sck fall that ends bit 8
      // and takes the place of that shift
      shift_q <= rd_data;
    end
    else if (pins.ssel_active && pins.sck_fall)
    begin
      // next bit up, zero fill behind it
      shift_q <= {shift_q[spi_pkg::BYTE_W-2:0], 1'b0};
    end
  end

  // msb first; single slave assumed, no tri-state
  assign miso = shift_q[spi_pkg::BYTE_W-1];

endmodule

// File: src/spi_reg_bank.sv
`timescale 1ns/1ps

module spi_reg_bank #(
  parameter int NUM_REGS = spi_pkg::NUM_REGS_DEFAULT
) (
  input  logic                                clk,
  input  logic                                rst_n,
  spi_pin_if.dst                              pins,
  input  logic                                wr_en,
  input  spi_pkg::reg_addr_t                  wr_addr,
  input  spi_pkg::spi_byte_t                  wr_data,
  input  spi_pkg::reg_addr_t                  rd_addr,
  output spi_pkg::spi_byte_t                  rd_data,
  output logic [NUM_REGS*spi_pkg::BYTE_W-1:0] reg_flat
);

  // message counter lives at the top address
  localparam spi_pkg::reg_addr_t CNT_ADDR = spi_pkg::reg_addr_t'(NUM_REGS - 1);

  // writable registers only, the counter is kept apart
  spi_pkg::spi_byte_t regs_q [NUM_REGS-1];
  spi_pkg::spi_byte_t msg_cnt;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_REGS - 1; i++)
        regs_q[i] <= '0;
    end
    // counter address and anything above it are dropped
    else if (wr_en && (wr_addr < CNT_ADDR))
    begin
      regs_q[wr_addr] <= wr_data;
    end
  end

  // steps once per ssel falling edge, wraps at 256
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      msg_cnt <= '0;
    else if (pins.frame_start)
      msg_cnt <= msg_cnt + 1'b1;
  end

  // asynchronous read, zero beyond the array
  always_comb
  begin
    if (rd_addr == CNT_ADDR)
      rd_data = msg_cnt;
    else if (rd_addr < CNT_ADDR)
      rd_data = regs_q[rd_addr];
    else
      rd_data = '0;
  end

  // flat view, register i at byte lane i, counter in the top lane
  always_comb
  begin
    for (int i = 0; i < NUM_REGS - 1; i++)
      reg_flat[i*spi_pkg::BYTE_W +: spi_pkg::BYTE_W] = regs_q[i];
    reg_flat[(NUM_REGS-1)*spi_pkg::BYTE_W +: spi_pkg::BYTE_W] = msg_cnt;
  end

endmodule

// File: src/spi_frame_ctrl.sv
`timescale 1ns/1ps

module spi_frame_ctrl #(
  parameter int NUM_REGS = spi_pkg::NUM_REGS_DEFAULT
) (
  input  logic               clk,
  input  logic               rst_n,
  spi_pin_if.dst             pins,
  input  logic               byte_valid,
  input  spi_pkg::spi_byte_t byte_data,
  output logic               tx_load,
  output spi_pkg::reg_addr_t rd_addr,
  output logic               wr_en,
  output spi_pkg::reg_addr_t wr_addr,
  output spi_pkg::spi_byte_t wr_data
);

  // the bank does the range checks; only the size itself is checked here
  if ((NUM_REGS < 2) || (NUM_REGS > (1 << spi_pkg::ADDR_W)))
  begin : g_bad_num_regs
    $error("NUM_REGS out of range for the address field");
  end

  spi_pkg::frame_state_t state_q;
  spi_pkg::frame_state_t state_d;

  spi_pkg::reg_addr_t addr_q;
  spi_pkg::spi_byte_t data_q;
  // command said write
  logic wr_frame_q;
  // miso already loaded in this read frame
  logic load_done_q;
  logic wr_en_q;

  logic cmd_accept;
  logic data_accept;

  // command byte completes while waiting for it
  assign cmd_accept = (state_q == spi_pkg::CMD) && byte_valid;
  // data byte completes in either data state
  assign data_accept = ((state_q == spi_pkg::DATA_WR) || (state_q == spi_pkg::DATA_RD))
                       && byte_valid;

  always_comb
  begin
    state_d = state_q;
    // ssel rising closes the frame from any state
    if (pins.frame_end)
      state_d = spi_pkg::IDLE;
    else
    begin
      case (state_q)
        spi_pkg::IDLE:
          if (pins.frame_start)
            state_d = spi_pkg::CMD;
        spi_pkg::CMD:
          if (byte_valid)
            state_d = byte_data[spi_pkg::CMD_WRITE_BIT] ? spi_pkg::DATA_WR : spi_pkg::DATA_RD;
        spi_pkg::DATA_WR,
        spi_pkg::DATA_RD:
          if (byte_valid)
            state_d = spi_pkg::DONE;
        // extra bytes are ignored until ssel rises
        spi_pkg::DONE:
          state_d = spi_pkg::DONE;
        default:
          state_d = spi_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= spi_pkg::IDLE;
      addr_q      <= '0;
      data_q      <= '0;
      wr_frame_q  <= 1'b0;
      load_done_q <= 1'b0;
      wr_en_q     <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // commit only a complete write frame, one cycle after frame_end
      wr_en_q <= pins.frame_end && (state_q == spi_pkg::DONE) && wr_frame_q;
      if (cmd_accept)
      begin
        // bits 6:4 of the command are don't care
        addr_q      <= byte_data[spi_pkg::CMD_ADDR_LSB +: spi_pkg::ADDR_W];
        wr_frame_q  <= byte_data[spi_pkg::CMD_WRITE_BIT];
        load_done_q <= 1'b0;
      end
      if (tx_load)
        load_done_q <= 1'b1;
      if (data_accept)
        data_q <= byte_data;
    end
  end

  // first sck fall in DATA_RD ends bit 8, load the addressed register there
  assign tx_load = (state_q == spi_pkg::DATA_RD) && pins.sck_fall && !load_done_q;

  // address goes out unchanged on both ports
  assign rd_addr = addr_q;
  assign wr_addr = addr_q;
  assign wr_data = data_q;
  assign wr_en   = wr_en_q;

endmodule

// File: src/spi_slave_top.sv
`timescale 1ns/1ps

module spi_slave_top #(
  parameter int SYNC_STAGES = 3,
  parameter int NUM_REGS    = spi_pkg::NUM_REGS_DEFAULT
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                sck,
  input  logic                                ssel,
  input  logic                                mosi,
  output logic                                miso,
  output logic                                rx_byte_strobe,
  output spi_pkg::spi_byte_t                  rx_byte,
  output logic                                wr_strobe,
  output spi_pkg::reg_addr_t                  wr_addr,
  output spi_pkg::spi_byte_t                  wr_data,
  output logic [NUM_REGS*spi_pkg::BYTE_W-1:0] regs
);

  // synchronized pin events shared by every block
  spi_pin_if pins ();

  // read path from controller to bank to miso shifter
  logic               tx_load;
  spi_pkg::reg_addr_t rd_addr;
  spi_pkg::spi_byte_t rd_data;

  spi_pin_sync #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_pin_sync (
    .clk   (clk),
    .rst_n (rst_n),
    .sck   (sck),
    .ssel  (ssel),
    .mosi  (mosi),
    .pins  (pins.src)
  );

  // byte strobe feeds the controller and leaves the top as is
  spi_rx_shift u_rx_shift (
    .clk        (clk),
    .rst_n      (rst_n),
    .pins       (pins.dst),
    .byte_valid (rx_byte_strobe),
    .byte_data  (rx_byte)
  );

  spi_tx_shift u_tx_shift (
    .clk     (clk),
    .rst_n   (rst_n),
    .pins    (pins.dst),
    .tx_load (tx_load),
    .rd_data (rd_data),
    .miso    (miso)
  );

  // write commit strobe doubles as the top level wr_strobe
  spi_reg_bank #(
    .NUM_REGS (NUM_REGS)
  ) u_reg_bank (
    .clk      (clk),
    .rst_n    (rst_n),
    .pins     (pins.dst),
    .wr_en    (wr_strobe),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .reg_flat (regs)
  );

  spi_frame_ctrl #(
    .NUM_REGS (NUM_REGS)
  ) u_frame_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .pins       (pins.dst),
    .byte_valid (rx_byte_strobe),
    .byte_data  (rx_byte),
    .tx_load    (tx_load),
    .rd_addr    (rd_addr),
    .wr_en      (wr_strobe),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data)
  );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int HALF_PERIOD_NS = 5,
  parameter int RESET_CYCLES   = 3
) (
  output logic clk,
  output logic rst_n
);

  // free running, 10 ns period with the default half period
  initial
  begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  // reset held over the first rising edges, released on a falling edge
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// File: test/spi_slave_sva.sv
`timescale 1ns/1ps

module spi_slave_sva #(
  parameter int NUM_REGS = spi_pkg::NUM_REGS_DEFAULT
) (
  input logic                                clk,
  input logic                                rst_n,
  input logic                                ssel,
  input logic                                miso,
  input logic                                rx_byte_strobe,
  input logic                                wr_strobe,
  input logic [NUM_REGS*spi_pkg::BYTE_W-1:0] regs
);

  // message counter lane sits on top of the writable lanes
  localparam int CNT_LSB = (NUM_REGS - 1) * spi_pkg::BYTE_W;

  // failures seen so far, summed into the test verdict
  int fail_cnt = 0;

  // outputs come out of reset clean
  reset_values: assert property (@(posedge clk)
    $rose(rst_n) |-> (!wr_strobe && !rx_byte_strobe && !miso && (regs == '0)))
  else
  begin
    fail_cnt++;
    $error("outputs not at reset values after reset");
  end

  // byte strobe is a single pulse
  rx_single: assert property (@(posedge clk) disable iff (!rst_n)
    rx_byte_strobe |=> !rx_byte_strobe)
  else
  begin
    fail_cnt++;
    $error("rx_byte_strobe high for more than one cycle");
  end

  wr_single: assert property (@(posedge clk) disable iff (!rst_n)
    wr_strobe |=> !wr_strobe)
  else
  begin
    fail_cnt++;
    $error("wr_strobe high for more than one cycle");
  end

  // commit only once ssel has gone back high
  wr_after_frame: assert property (@(posedge clk) disable iff (!rst_n)
    wr_strobe |-> ssel)
  else
  begin
    fail_cnt++;
    $error("wr_strobe while ssel still low");
  end

  // writable lanes move only right after a commit
  regs_on_commit: assert property (@(posedge clk) disable iff (!rst_n)
    !$past(wr_strobe) |-> $stable(regs[CNT_LSB-1:0]))
  else
  begin
    fail_cnt++;
    $error("regs changed without a write commit");
  end

  // counter lane only ever steps by one, writes never land there
  cnt_step: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(regs[CNT_LSB +: 8]) |-> (regs[CNT_LSB +: 8] == $past(regs[CNT_LSB +: 8]) + 8'd1))
  else
  begin
    fail_cnt++;
    $error("message counter lane did not step by one");
  end

endmodule

bind spi_slave_top spi_slave_sva #(
  .NUM_REGS (NUM_REGS)
) sva0 (
  .clk            (clk),
  .rst_n          (rst_n),
  .ssel           (ssel),
  .miso           (miso),
  .rx_byte_strobe (rx_byte_strobe),
  .wr_strobe      (wr_strobe),
  .regs           (regs)
);

// File: test/spi_slave_tb.sv
`timescale 1ns/1ps

module spi_slave_tb;

  localparam int NUM_REGS = 16;
  // ssel lead, 16 bits of 12 clk each, tail and idle gap
  localparam int FRAME_CYCLES = 6 + 16 * 12 + 6 + 8;
  localparam int NUM_FRAMES   = 37;
  localparam int CYCLE_LIMIT  = 4 * (NUM_FRAMES * FRAME_CYCLES + 20);
  localparam spi_pkg::reg_addr_t CNT_ADDR = spi_pkg::reg_addr_t'(NUM_REGS - 1);

  logic clk;
  logic rst_n;
  logic sck;
  logic ssel;
  logic mosi;
  logic miso;
  logic rx_byte_strobe;
  spi_pkg::spi_byte_t rx_byte;
  logic wr_strobe;
  spi_pkg::reg_addr_t wr_addr;
  spi_pkg::spi_byte_t wr_data;
  logic [NUM_REGS*spi_pkg::BYTE_W-1:0] regs;

  // reference model of the bank and the message counter
  spi_pkg::spi_byte_t model [NUM_REGS];
  spi_pkg::spi_byte_t msg_cnt;
  // bytes and commits the DUT still owes, oldest first
  spi_pkg::spi_byte_t rx_exp_q [$];
  logic [11:0] wr_exp_q [$];
  spi_pkg::spi_byte_t rx_head;
  logic [11:0] wr_head;

  logic [31:0] lfsr;
  // main flow and monitor keep separate counts
  int main_errs;
  int mon_errs;
  int err_mark;
  int tests_pass;
  int tests_fail;
  int cycles;
  spi_pkg::spi_byte_t r;
  spi_pkg::spi_byte_t d;
  spi_pkg::reg_addr_t a;

  tb_clock clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  spi_slave_top #(
    .SYNC_STAGES (3),
    .NUM_REGS    (NUM_REGS)
  ) dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .sck            (sck),
    .ssel           (ssel),
    .mosi           (mosi),
    .miso           (miso),
    .rx_byte_strobe (rx_byte_strobe),
    .rx_byte        (rx_byte),
    .wr_strobe      (wr_strobe),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .regs           (regs)
  );

  task automatic value_error(input string name, input logic [7:0] exp, input logic [7:0] got);
    $display("ERROR %0t %s expected %h got %h", $time, name, exp, got);
  endtask

  task automatic fail_note(input string msg);
    $display("%0t: %s", $time, msg);
  endtask

  task automatic wait_clks(input int n);
    repeat (n) @(negedge clk);
  endtask

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output spi_pkg::spi_byte_t val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      val = {val[6:0], lfsr[0]};
    end
  endtask

  // writable addresses only, redraw on the counter slot
  task automatic rand_wr_addr(output spi_pkg::reg_addr_t addr);
    spi_pkg::spi_byte_t v;
    take_bits(4, v);
    while (v[3:0] == CNT_ADDR)
      take_bits(4, v);
    addr = v[3:0];
  endtask

  // mode 0 master, 6 clk per sck phase; nbits below 16 aborts the frame
  task automatic spi_frame(input spi_pkg::spi_byte_t cmd, input spi_pkg::spi_byte_t data,
                           input int nbits, input logic rd_check, input spi_pkg::spi_byte_t rd_exp);
    logic [15:0] word;
    spi_pkg::spi_byte_t rd_byte;
    logic exp_bit;
    word = {cmd, data};
    rd_byte = rd_exp;
    // counter steps on every ssel fall
    msg_cnt = msg_cnt + 8'd1;
    ssel = 1'b0;
    wait_clks(6);
    for (int i = 0; i < nbits; i++)
    begin
      // only bytes that finish owe a strobe
      if ((i % 8 == 0) && (i + 8 <= nbits))
        rx_exp_q.push_back(word[15:8]);
      mosi = word[15];
      word = {word[14:0], 1'b0};
      wait_clks(6);
      // miso is zero outside the data byte of a read
      if (rd_check && (i >= 8))
      begin
        exp_bit = rd_byte[7];
        rd_byte = {rd_byte[6:0], 1'b0};
      end
      else
        exp_bit = 1'b0;
      assert (miso == exp_bit)
      else
      begin
        value_error("miso", {7'd0, exp_bit}, {7'd0, miso});
        main_errs++;
      end
      sck = 1'b1;
      wait_clks(6);
      sck = 1'b0;
    end
    wait_clks(6);
    ssel = 1'b1;
    mosi = 1'b0;
    wait_clks(8);
  endtask

  task automatic write_reg(input spi_pkg::reg_addr_t addr, input spi_pkg::spi_byte_t data);
    wr_exp_q.push_back({addr, data});
    if (addr != CNT_ADDR)
      model[addr] = data;
    // bits 6:4 carry junk the slave ignores
    spi_frame({1'b1, 3'b101, addr}, data, 16, 1'b0, 8'h00);
  endtask

  task automatic read_reg(input spi_pkg::reg_addr_t addr, input spi_pkg::spi_byte_t junk);
    spi_pkg::spi_byte_t exp_b;
    // counter value includes this frame
    if (addr == CNT_ADDR)
      exp_b = msg_cnt + 8'd1;
    else
      exp_b = model[addr];
    spi_frame({1'b0, 3'b011, addr}, junk, 16, 1'b1, exp_b);
  endtask

  task automatic check_regs();
    spi_pkg::spi_byte_t exp_b;
    for (int i = 0; i < NUM_REGS; i++)
    begin
      exp_b = (i == NUM_REGS - 1) ? msg_cnt : model[i];
      assert (regs[i*8 +: 8] == exp_b)
      else
      begin
        value_error($sformatf("regs[%0d]", i), exp_b, regs[i*8 +: 8]);
        main_errs++;
      end
    end
  endtask

  task automatic end_test(input string name);
    int total;
    if (rx_exp_q.size() != 0)
    begin
      fail_note("a completed byte gave no rx_byte_strobe");
      main_errs++;
      rx_exp_q.delete();
    end
    if (wr_exp_q.size() != 0)
    begin
      fail_note("a write frame gave no wr_strobe");
      main_errs++;
      wr_exp_q.delete();
    end
    total = main_errs + mon_errs + dut0.sva0.fail_cnt;
    if (total == err_mark)
      tests_pass++;
    else
      tests_fail++;
    $display("test %s done, %0d errors", name, total - err_mark);
    err_mark = total;
  endtask

  // strobes sampled mid cycle, where outputs are settled
  always @(negedge clk)
  begin
    if (rx_byte_strobe)
    begin
      if (rx_exp_q.size() == 0)
      begin
        fail_note("rx_byte_strobe with no completed byte");
        mon_errs++;
      end
      else
      begin
        rx_head = rx_exp_q.pop_front();
        assert (rx_byte == rx_head)
        else
        begin
          value_error("rx_byte", rx_head, rx_byte);
          mon_errs++;
        end
      end
    end
    if (wr_strobe)
    begin
      if (wr_exp_q.size() == 0)
      begin
        fail_note("wr_strobe with no complete write frame");
        mon_errs++;
      end
      else
      begin
        wr_head = wr_exp_q.pop_front();
        assert ((wr_addr == wr_head[11:8]) && (wr_data == wr_head[7:0]))
        else
        begin
          value_error("wr_addr", {4'h0, wr_head[11:8]}, {4'h0, wr_addr});
          value_error("wr_data", wr_head[7:0], wr_data);
          mon_errs++;
        end
      end
    end
  end

  // watchdog sized from the frame count
  initial
  begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the test sequence did not finish", cycles);
    $display("Test FAILED");
    $finish;
  end

  initial
  begin
    sck = 1'b0;
    ssel = 1'b1;
    mosi = 1'b0;
    lfsr = 32'hef59;
    msg_cnt = '0;
    main_errs = 0;
    mon_errs = 0;
    err_mark = 0;
    tests_pass = 0;
    tests_fail = 0;
    for (int i = 0; i < NUM_REGS; i++)
      model[i] = '0;
    @(posedge rst_n);
    @(negedge clk);

    // clean outputs right after reset, also covered in the sva
    assert (!wr_strobe && !rx_byte_strobe && !miso)
    else
    begin
      fail_note("strobes or miso not low after reset");
      main_errs++;
    end
    check_regs();
    end_test("reset state");

    // random reads, every byte must come back on rx_byte
    repeat (4)
    begin
      take_bits(4, r);
      take_bits(8, d);
      read_reg(r[3:0], d);
    end
    end_test("received bytes");

    repeat (20)
    begin
      rand_wr_addr(a);
      take_bits(8, d);
      write_reg(a, d);
      check_regs();
    end
    end_test("register writes");

    repeat (8)
    begin
      rand_wr_addr(a);
      take_bits(8, d);
      read_reg(a, d);
    end
    end_test("read-back");

    // counter reads, and a write that must not touch it
    take_bits(8, d);
    read_reg(CNT_ADDR, d);
    take_bits(8, d);
    write_reg(CNT_ADDR, d);
    check_regs();
    read_reg(CNT_ADDR, 8'h00);
    end_test("message counter");

    // write cut after 5 data bits, then a write command with no data byte
    rand_wr_addr(a);
    take_bits(8, d);
    spi_frame({1'b1, 3'b000, a}, d, 13, 1'b0, 8'h00);
    check_regs();
    spi_frame({1'b1, 3'b000, a}, 8'h00, 8, 1'b0, 8'h00);
    check_regs();
    end_test("aborted frames");

    $display("tests passed %0d failed %0d", tests_pass, tests_fail);
    if (tests_fail == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// File: flist.f
src/spi_pkg.sv
src/spi_pin_if.sv
src/spi_pin_sync.sv
src/spi_rx_shift.sv
src/spi_tx_shift.sv
src/spi_reg_bank.sv
src/spi_frame_ctrl.sv
src/spi_slave_top.sv
test/tb_clock.sv
test/spi_slave_sva.sv
test/spi_slave_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the spi slave testbench with verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module spi_slave_tb -f flist.f \
  -o sim_spi_slave > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_spi_slave +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log && exit 0 || exit 1
